// File: rename_unit.f
design/rename_reg_pkg.sv
design/free_list_pkg.sv
design/arch_free_list.sv
design/spec_free_list.sv
design/arch_map_table.sv
design/spec_map_table.sv
design/rename_unit.sv
tb/tb_rename_unit.sv

// File: tb/tb_rename_unit.sv
// ====================
// Testbench for the rename unit, two rename lanes and two commit lanes
// Expected values come from a queue model of both copies
// Commit lanes always name the oldest renamed but uncommitted instructions
// Stops at the first mismatch
// ====================

`timescale 1ns/10ps

module tb_rename_unit
  import rename_reg_pkg::*;
  import free_list_pkg::*;
();

  localparam int unsigned RENAME_WIDTH = 2;
  localparam int unsigned COMMIT_WIDTH = 2;
  localparam int          CLK_PERIOD   = 100;
  localparam int          WAIT_LIMIT   = 20;

  // Operation kinds
  localparam logic [1:0] OP_RENAME   = 2'd0;
  localparam logic [1:0] OP_COMMIT   = 2'd1;
  localparam logic [1:0] OP_FLUSH    = 2'd2;
  localparam logic [1:0] OP_FLUSH_CM = 2'd3;

  // One table row, rename and commit lanes side by side
  typedef struct packed {
    logic [1:0]  kind;
    logic [1:0]  rn_valid;
    logic [1:0]  cm_valid;
    logic        rnd;
    areg_t [1:0] src1;
    areg_t [1:0] src2;
    areg_t [1:0] dst;
  } op_t;

  logic                     clk;
  logic                     rst_n;
  logic                     flush_i;
  logic [RENAME_WIDTH-1:0]  rn_valid_i;
  areg_t [RENAME_WIDTH-1:0] rn_src1_i;
  areg_t [RENAME_WIDTH-1:0] rn_src2_i;
  areg_t [RENAME_WIDTH-1:0] rn_dst_i;
  logic                     rn_ready_o;
  preg_t [RENAME_WIDTH-1:0] rn_src1_preg_o;
  preg_t [RENAME_WIDTH-1:0] rn_src2_preg_o;
  preg_t [RENAME_WIDTH-1:0] rn_dst_preg_o;
  preg_t [RENAME_WIDTH-1:0] rn_old_preg_o;
  logic [COMMIT_WIDTH-1:0]  cm_valid_i;
  areg_t [COMMIT_WIDTH-1:0] cm_dst_i;
  preg_t [COMMIT_WIDTH-1:0] cm_preg_i;
  fl_cnt_t                  free_cnt_o;

  // ====================
  // Model state
  // ====================

  preg_t  spec_map [ARCH_REG_NUM];
  preg_t  arch_map [ARCH_REG_NUM];
  preg_t  spec_fl [$];
  preg_t  arch_fl [$];
  // Renamed but not yet committed, oldest first
  areg_t  fly_dst [$];
  preg_t  fly_preg [$];
  op_t    ops [$];
  integer seed;

  rename_unit #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .rn_valid_i     (rn_valid_i),
    .rn_src1_i      (rn_src1_i),
    .rn_src2_i      (rn_src2_i),
    .rn_dst_i       (rn_dst_i),
    .rn_ready_o     (rn_ready_o),
    .rn_src1_preg_o (rn_src1_preg_o),
    .rn_src2_preg_o (rn_src2_preg_o),
    .rn_dst_preg_o  (rn_dst_preg_o),
    .rn_old_preg_o  (rn_old_preg_o),
    .cm_valid_i     (cm_valid_i),
    .cm_dst_i       (cm_dst_i),
    .cm_preg_i      (cm_preg_i),
    .free_cnt_o     (free_cnt_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // ====================
  // Compare helpers
  // ====================

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_cnt(input string name, input fl_cnt_t got, input fl_cnt_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // Poll on falling edges, bounded
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (rn_ready_o !== 1'b1) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("timeout: rn_ready_o never went high after reset");
        stop_run();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // ====================
  // Model and table
  // ====================

  // Identity maps, 32..63 free in order
  task automatic reset_model();
    for (int a = 0; a < ARCH_REG_NUM; a++) begin
      spec_map[a] = preg_t'(a);
      arch_map[a] = preg_t'(a);
    end
    spec_fl.delete();
    arch_fl.delete();
    fly_dst.delete();
    fly_preg.delete();
    for (int i = 0; i < FL_DEPTH; i++) begin
      spec_fl.push_back(preg_t'(ARCH_REG_NUM + i));
      arch_fl.push_back(preg_t'(ARCH_REG_NUM + i));
    end
  endtask

  task automatic add_op(input logic [1:0] kind, input logic [1:0] rn_valid,
                        input logic [1:0] cm_valid, input logic rnd);
    op_t op;
    op          = '0;
    op.kind     = kind;
    op.rn_valid = rn_valid;
    op.cm_valid = cm_valid;
    op.rnd      = rnd;
    ops.push_back(op);
  endtask

  // Rename row with fixed registers, lane 0 then lane 1
  task automatic add_directed(input logic [1:0] rn_valid, input int s1_0, input int s2_0,
                              input int d_0, input int s1_1, input int s2_1, input int d_1);
    op_t op;
    op          = '0;
    op.kind     = OP_RENAME;
    op.rn_valid = rn_valid;
    op.src1[0]  = areg_t'(s1_0);
    op.src2[0]  = areg_t'(s2_0);
    op.dst[0]   = areg_t'(d_0);
    op.src1[1]  = areg_t'(s1_1);
    op.src2[1]  = areg_t'(s2_1);
    op.dst[1]   = areg_t'(d_1);
    ops.push_back(op);
  endtask

  task automatic build_table();
    // Bypass to lane 1 and repeated destination
    add_directed(2'b11, 3, 4, 5, 5, 6, 5);
    // Reads after the fire
    add_directed(2'b01, 5, 5, 7, 0, 0, 0);
    add_op(OP_COMMIT, 2'b00, 2'b11, 1'b0);
    // Drain reset contents, then the freed 5 and 32
    for (int i = 0; i < 15; i++) begin
      add_op(OP_RENAME, 2'b11, 2'b00, 1'b1);
    end
    // One entry left, two-lane group held
    add_op(OP_RENAME, 2'b11, 2'b00, 1'b1);
    add_op(OP_RENAME, 2'b01, 2'b00, 1'b1);
    add_op(OP_RENAME, 2'b10, 2'b00, 1'b1);
    add_op(OP_COMMIT, 2'b00, 2'b10, 1'b0);
    // Held group with commits in the same cycle
    add_op(OP_RENAME, 2'b11, 2'b11, 1'b1);
    add_op(OP_RENAME, 2'b11, 2'b01, 1'b1);
    // Flush wins over a presented group
    add_op(OP_FLUSH, 2'b11, 2'b00, 1'b1);
    add_directed(2'b11, 5, 7, 9, 9, 0, 10);
    add_op(OP_RENAME, 2'b11, 2'b00, 1'b1);
    add_op(OP_RENAME, 2'b11, 2'b00, 1'b1);
    add_op(OP_COMMIT, 2'b00, 2'b01, 1'b0);
    add_op(OP_FLUSH_CM, 2'b00, 2'b11, 1'b0);
    // r10 must show the commit from the flush cycle
    add_directed(2'b11, 10, 9, 10, 10, 5, 3);
    add_op(OP_RENAME, 2'b01, 2'b00, 1'b1);
    add_op(OP_COMMIT, 2'b00, 2'b11, 1'b0);
    add_op(OP_RENAME, 2'b11, 2'b10, 1'b1);
    // Allocate down to the registers freed in the flush cycle
    for (int i = 0; i < 14; i++) begin
      add_op(OP_RENAME, 2'b11, 2'b00, 1'b1);
    end
  endtask

  // One cycle: drive, check, then step the model over the edge
  task automatic apply_op(input op_t op);
    preg_t tmp_map [ARCH_REG_NUM];
    preg_t exp_src1 [RENAME_WIDTH];
    preg_t exp_src2 [RENAME_WIDTH];
    preg_t exp_dst [RENAME_WIDTH];
    preg_t exp_old [RENAME_WIDTH];
    int    n_rn;
    int    k;
    logic  exp_ready;
    areg_t c_dst;
    preg_t c_preg;
    preg_t freed;
    if (op.rnd) begin
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        op.src1[i] = areg_t'($random(seed));
        op.src2[i] = areg_t'($random(seed));
        op.dst[i]  = areg_t'($random(seed));
      end
    end
    @(negedge clk);
    // State left by the previous edge
    check_cnt("free_cnt_o", free_cnt_o, fl_cnt_t'(spec_fl.size()));
    flush_i    = (op.kind == OP_FLUSH) || (op.kind == OP_FLUSH_CM);
    rn_valid_i = op.rn_valid;
    rn_src1_i  = op.src1;
    rn_src2_i  = op.src2;
    rn_dst_i   = op.dst;
    cm_valid_i = op.cm_valid;
    k = 0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      cm_dst_i[i]  = '0;
      cm_preg_i[i] = '0;
      if (op.cm_valid[i]) begin
        if (k >= fly_dst.size()) begin
          $display("table commits more instructions than are in flight");
          stop_run();
        end
        cm_dst_i[i]  = fly_dst[k];
        cm_preg_i[i] = fly_preg[k];
        k++;
      end
    end
    // Walk the group lane by lane on a scratch map
    n_rn      = $countones(op.rn_valid);
    exp_ready = (spec_fl.size() >= n_rn);
    tmp_map   = spec_map;
    k = 0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      if (op.rn_valid[i]) begin
        exp_src1[i] = tmp_map[op.src1[i]];
        exp_src2[i] = tmp_map[op.src2[i]];
        exp_old[i]  = tmp_map[op.dst[i]];
        exp_dst[i]  = (k < spec_fl.size()) ? spec_fl[k] : preg_t'(0);
        tmp_map[op.dst[i]] = exp_dst[i];
        k++;
      end
    end
    #(CLK_PERIOD/4);
    if (!flush_i) begin
      check_ready("rn_ready_o", rn_ready_o, exp_ready);
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (exp_ready && op.rn_valid[i]) begin
          check_preg($sformatf("rn_src1_preg_o[%0d]", i), rn_src1_preg_o[i], exp_src1[i]);
          check_preg($sformatf("rn_src2_preg_o[%0d]", i), rn_src2_preg_o[i], exp_src2[i]);
          check_preg($sformatf("rn_dst_preg_o[%0d]", i), rn_dst_preg_o[i], exp_dst[i]);
          check_preg($sformatf("rn_old_preg_o[%0d]", i), rn_old_preg_o[i], exp_old[i]);
        end
      end
    end
    // Commits, oldest first; replaced mapping goes to both tails
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (op.cm_valid[i]) begin
        c_dst  = fly_dst.pop_front();
        c_preg = fly_preg.pop_front();
        freed  = arch_map[c_dst];
        arch_map[c_dst] = c_preg;
        void'(arch_fl.pop_front());
        arch_fl.push_back(freed);
        spec_fl.push_back(freed);
      end
    end
    if (flush_i) begin
      spec_map = arch_map;
      spec_fl  = arch_fl;
      fly_dst.delete();
      fly_preg.delete();
    end else if (exp_ready && (n_rn > 0)) begin
      spec_map = tmp_map;
      for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (op.rn_valid[i]) begin
          void'(spec_fl.pop_front());
          fly_dst.push_back(op.dst[i]);
          fly_preg.push_back(exp_dst[i]);
        end
      end
    end
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    seed       = 50;
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    rn_valid_i = '0;
    rn_src1_i  = '0;
    rn_src2_i  = '0;
    rn_dst_i   = '0;
    cm_valid_i = '0;
    cm_dst_i   = '0;
    cm_preg_i  = '0;
    reset_model();
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_ready();
    for (int i = 0; i < ops.size(); i++) begin
      apply_op(ops[i]);
    end
    // Idle cycle, then the last count
    @(negedge clk);
    flush_i    = 1'b0;
    rn_valid_i = '0;
    cm_valid_i = '0;
    check_cnt("free_cnt_o", free_cnt_o, fl_cnt_t'(spec_fl.size()));
    $display("Testbench passed");
    $finish;
  end

endmodule : tb_rename_unit

// File: design/rename_unit.sv
// ====================
// Register rename top level
// Rename outputs are combinational, valid while rn_ready_o is high
// Commits have no back-pressure and must name committed mappings
// Flush restores the full committed state, no partial recovery
// ====================

`timescale 1ns/10ps

module rename_unit
  import rename_reg_pkg::*;
  import free_list_pkg::*;
#(
  parameter int unsigned RENAME_WIDTH = 2,
  parameter int unsigned COMMIT_WIDTH = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            flush_i,
  // Rename group
  input  logic [RENAME_WIDTH-1:0]         rn_valid_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_src1_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_src2_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_dst_i,
  output logic                            rn_ready_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_src1_preg_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_src2_preg_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_dst_preg_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_old_preg_o,
  // Commit group
  input  logic [COMMIT_WIDTH-1:0]         cm_valid_i,
  input  areg_t [COMMIT_WIDTH-1:0]        cm_dst_i,
  input  preg_t [COMMIT_WIDTH-1:0]        cm_preg_i,
  output fl_cnt_t                         free_cnt_o
);

  // Commit side to speculative side
  preg_t [COMMIT_WIDTH-1:0] freed_preg;
  preg_t [ARCH_REG_NUM-1:0] arch_map_next;
  fl_mem_t                  arch_fl_next;
  fl_ptr_t                  arch_head_next;
  fl_cnt_t                  arch_cnt_next;

  // Free list to map table
  preg_t [RENAME_WIDTH-1:0] alloc_preg;
  logic                     rn_ready;

  // ====================
  // Committed copy
  // ====================

  arch_map_table #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_arch_map_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .cm_valid_i      (cm_valid_i),
    .cm_dst_i        (cm_dst_i),
    .cm_preg_i       (cm_preg_i),
    .freed_preg_o    (freed_preg),
    .arch_map_next_o (arch_map_next)
  );

  arch_free_list #(.COMMIT_WIDTH(COMMIT_WIDTH)) u_arch_free_list (
    .clk              (clk),
    .rst_n            (rst_n),
    .cm_valid_i       (cm_valid_i),
    .freed_preg_i     (freed_preg),
    .arch_fl_next_o   (arch_fl_next),
    .arch_head_next_o (arch_head_next),
    .arch_cnt_next_o  (arch_cnt_next)
  );

  // ====================
  // Speculative copy
  // ====================

  spec_free_list #(
    .RENAME_WIDTH (RENAME_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_spec_free_list (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush_i),
    .rn_valid_i       (rn_valid_i),
    .cm_valid_i       (cm_valid_i),
    .freed_preg_i     (freed_preg),
    .arch_fl_next_i   (arch_fl_next),
    .arch_head_next_i (arch_head_next),
    .arch_cnt_next_i  (arch_cnt_next),
    .alloc_preg_o     (alloc_preg),
    .rn_ready_o       (rn_ready),
    .free_cnt_o       (free_cnt_o)
  );

  spec_map_table #(.RENAME_WIDTH(RENAME_WIDTH)) u_spec_map_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (flush_i),
    .rn_valid_i      (rn_valid_i),
    .rn_ready_i      (rn_ready),
    .rn_src1_i       (rn_src1_i),
    .rn_src2_i       (rn_src2_i),
    .rn_dst_i        (rn_dst_i),
    .alloc_preg_i    (alloc_preg),
    .arch_map_next_i (arch_map_next),
    .rn_src1_preg_o  (rn_src1_preg_o),
    .rn_src2_preg_o  (rn_src2_preg_o),
    .rn_old_preg_o   (rn_old_preg_o)
  );

  // New destinations come straight from the free list
  assign rn_dst_preg_o = alloc_preg;
  assign rn_ready_o    = rn_ready;

endmodule : rename_unit

// File: design/spec_map_table.sv
// ====================
// Speculative map table
// Lookups bypass from earlier lanes of the same group
// Written only when the whole group fires
// Flush loads the committed next-state table
// ====================

`timescale 1ns/10ps

module spec_map_table
  import rename_reg_pkg::*;
#(
  parameter int unsigned RENAME_WIDTH = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            flush_i,
  input  logic [RENAME_WIDTH-1:0]         rn_valid_i,
  input  logic                            rn_ready_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_src1_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_src2_i,
  input  areg_t [RENAME_WIDTH-1:0]        rn_dst_i,
  input  preg_t [RENAME_WIDTH-1:0]        alloc_preg_i,
  input  preg_t [ARCH_REG_NUM-1:0]        arch_map_next_i,
  output preg_t [RENAME_WIDTH-1:0]        rn_src1_preg_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_src2_preg_o,
  output preg_t [RENAME_WIDTH-1:0]        rn_old_preg_o
);

  preg_t [ARCH_REG_NUM-1:0] map_q;
  preg_t [ARCH_REG_NUM-1:0] map_wr;

  logic fire;

  // Table read, then newest earlier lane writing the same register
  function automatic preg_t lookup(areg_t r, int unsigned lane);
    preg_t p;
    p = map_q[r];
    for (int unsigned j = 0; j < lane; j++) begin
      if (rn_valid_i[j] && (rn_dst_i[j] == r)) begin
        p = alloc_preg_i[j];
      end
    end
    return p;
  endfunction

  // ====================
  // Lookup
  // ====================

  always_comb begin
    for (int unsigned i = 0; i < RENAME_WIDTH; i++) begin
      rn_src1_preg_o[i] = lookup(rn_src1_i[i], i);
      rn_src2_preg_o[i] = lookup(rn_src2_i[i], i);
      // Old mapping goes to the reorder buffer
      rn_old_preg_o[i]  = lookup(rn_dst_i[i], i);
    end
  end

  // ====================
  // Update
  // ====================

  // Same firing rule as the free list
  assign fire = rn_ready_i && (|rn_valid_i);

  always_comb begin
    map_wr = map_q;
    // Lane order, last write wins
    for (int unsigned i = 0; i < RENAME_WIDTH; i++) begin
      if (rn_valid_i[i]) begin
        map_wr[rn_dst_i[i]] = alloc_preg_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned a = 0; a < ARCH_REG_NUM; a++) begin
        map_q[a] <= preg_t'(a);
      end
    end else if (flush_i) begin
      map_q <= arch_map_next_i;
    end else if (fire) begin
      map_q <= map_wr;
    end
  end

endmodule : spec_map_table

// File: design/arch_map_table.sv
// ====================
// Committed map table
// Lanes apply in order, later lanes win on the same register
// Yields the replaced register of each lane for freeing
// ====================

`timescale 1ns/10ps

module arch_map_table
  import rename_reg_pkg::*;
#(
  parameter int unsigned COMMIT_WIDTH = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [COMMIT_WIDTH-1:0]         cm_valid_i,
  input  areg_t [COMMIT_WIDTH-1:0]        cm_dst_i,
  input  preg_t [COMMIT_WIDTH-1:0]        cm_preg_i,
  output preg_t [COMMIT_WIDTH-1:0]        freed_preg_o,
  output preg_t [ARCH_REG_NUM-1:0]        arch_map_next_o
);

  preg_t [ARCH_REG_NUM-1:0] map_q;
  preg_t [ARCH_REG_NUM-1:0] map_d;

  // ====================
  // Commit walk
  // ====================

  always_comb begin
    map_d = map_q;
    for (int unsigned i = 0; i < COMMIT_WIDTH; i++) begin
      // Mapping before this lane, earlier lanes already applied
      freed_preg_o[i] = map_d[cm_dst_i[i]];
      if (cm_valid_i[i]) begin
        map_d[cm_dst_i[i]] = cm_preg_i[i];
      end
    end
  end

  // Flush restore source
  assign arch_map_next_o = map_d;

  // ====================
  // State
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping out of reset
      for (int unsigned a = 0; a < ARCH_REG_NUM; a++) begin
        map_q[a] <= preg_t'(a);
      end
    end else begin
      map_q <= map_d;
    end
  end

endmodule : arch_map_table

// File: design/spec_free_list.sv
// ====================
// Speculative free list
// A rename group is taken whole or not at all
// Flush wins over rename and loads the committed next state
// Freed registers are allocatable one cycle after commit
// ====================

`timescale 1ns/10ps

module spec_free_list
  import rename_reg_pkg::*;
  import free_list_pkg::*;
#(
  parameter int unsigned RENAME_WIDTH = 2,
  parameter int unsigned COMMIT_WIDTH = 2
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush_i,
  input  logic [RENAME_WIDTH-1:0]        rn_valid_i,
  input  logic [COMMIT_WIDTH-1:0]        cm_valid_i,
  input  preg_t [COMMIT_WIDTH-1:0]       freed_preg_i,
  input  fl_mem_t                        arch_fl_next_i,
  input  fl_ptr_t                        arch_head_next_i,
  input  fl_cnt_t                        arch_cnt_next_i,
  output preg_t [RENAME_WIDTH-1:0]       alloc_preg_o,
  output logic                           rn_ready_o,
  output fl_cnt_t                        free_cnt_o
);

  fl_mem_t fl_q;
  fl_ptr_t head_q;
  fl_ptr_t tail_q;
  fl_cnt_t cnt_q;

  // Lane counts
  fl_cnt_t n_rename;
  fl_cnt_t n_free;
  fl_cnt_t n_alloc;

  // Read and write walk pointers
  fl_ptr_t rd_ptr;
  fl_ptr_t wr_ptr;
  fl_mem_t fl_wr;

  logic    fire;

  // ====================
  // Allocation
  // ====================

  always_comb begin
    rd_ptr   = head_q;
    n_rename = '0;
    for (int unsigned i = 0; i < RENAME_WIDTH; i++) begin
      // Idle lanes see the next entry but do not consume it
      alloc_preg_o[i] = fl_q[rd_ptr];
      if (rn_valid_i[i]) begin
        rd_ptr   = rd_ptr + fl_ptr_t'(1);
        n_rename = n_rename + fl_cnt_t'(1);
      end
    end
  end

  // Enough entries for every valid lane
  assign rn_ready_o = (cnt_q >= n_rename);
  assign fire       = rn_ready_o && (|rn_valid_i);
  assign n_alloc    = fire ? n_rename : '0;
  assign free_cnt_o = cnt_q;

  // ====================
  // Frees from commit
  // ====================

  always_comb begin
    fl_wr  = fl_q;
    wr_ptr = tail_q;
    n_free = '0;
    for (int unsigned i = 0; i < COMMIT_WIDTH; i++) begin
      if (cm_valid_i[i]) begin
        fl_wr[wr_ptr] = freed_preg_i[i];
        wr_ptr        = wr_ptr + fl_ptr_t'(1);
        n_free        = n_free + fl_cnt_t'(1);
      end
    end
  end

  // ====================
  // State
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int unsigned i = 0; i < FL_DEPTH; i++) begin
        fl_q[i] <= preg_t'(ARCH_REG_NUM + i);
      end
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= fl_cnt_t'(FL_DEPTH);
    end else if (flush_i) begin
      // Copy committed state, same-cycle commits included
      fl_q   <= arch_fl_next_i;
      head_q <= arch_head_next_i;
      tail_q <= arch_head_next_i + fl_ptr_t'(arch_cnt_next_i);
      cnt_q  <= arch_cnt_next_i;
    end else begin
      fl_q   <= fl_wr;
      head_q <= fire ? rd_ptr : head_q;
      tail_q <= wr_ptr;
      cnt_q  <= cnt_q + n_free - n_alloc;
    end
  end

endmodule : spec_free_list

// File: design/arch_free_list.sv
// ====================
// Committed free list
// Commits never stall, every valid lane is applied
// Next state is exposed for a same-cycle flush restore
// ====================

`timescale 1ns/10ps

module arch_free_list
  import rename_reg_pkg::*;
  import free_list_pkg::*;
#(
  parameter int unsigned COMMIT_WIDTH = 2
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [COMMIT_WIDTH-1:0]        cm_valid_i,
  input  preg_t [COMMIT_WIDTH-1:0]       freed_preg_i,
  output fl_mem_t                        arch_fl_next_o,
  output fl_ptr_t                        arch_head_next_o,
  output fl_cnt_t                        arch_cnt_next_o
);

  // Current committed state
  fl_mem_t fl_q;
  fl_ptr_t head_q;
  fl_ptr_t tail_q;

  // Next state
  fl_mem_t fl_d;
  fl_ptr_t head_d;
  fl_ptr_t tail_d;

  // Valid commit lanes this cycle
  fl_cnt_t n_commit;

  // ====================
  // Next state
  // ====================

  always_comb begin
    fl_d     = fl_q;
    tail_d   = tail_q;
    n_commit = '0;
    for (int unsigned i = 0; i < COMMIT_WIDTH; i++) begin
      if (cm_valid_i[i]) begin
        // Old mapping goes back at the tail, lane order
        fl_d[tail_d] = freed_preg_i[i];
        tail_d       = tail_d + fl_ptr_t'(1);
        n_commit     = n_commit + fl_cnt_t'(1);
      end
    end
    // Each commit also retires the register it took at rename
    head_d = head_q + fl_ptr_t'(n_commit);
  end

  assign arch_fl_next_o   = fl_d;
  assign arch_head_next_o = head_d;
  // One free in and one retire out per commit, so the list stays full
  assign arch_cnt_next_o  = fl_cnt_t'(FL_DEPTH);

  // ====================
  // State
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Registers above the architectural range start free
      for (int unsigned i = 0; i < FL_DEPTH; i++) begin
        fl_q[i] <= preg_t'(ARCH_REG_NUM + i);
      end
      head_q <= '0;
      tail_q <= '0;
    end else begin
      fl_q   <= fl_d;
      head_q <= head_d;
      tail_q <= tail_d;
    end
  end

endmodule : arch_free_list

// File: design/free_list_pkg.sv
// ====================
// Free list storage types
// Depth covers every register not held by the map table
// Pointers wrap on their own, so depth must be a power of two
// ====================

package free_list_pkg;

  import rename_reg_pkg::*;

  // ====================
  // Sizes
  // ====================

  // Most free registers that can exist at one time
  parameter int unsigned FL_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;

  // ====================
  // Types
  // ====================

  // Circular head or tail pointer
  typedef logic [$clog2(FL_DEPTH)-1:0]   fl_ptr_t;

  // Entry count, 0 up to FL_DEPTH inclusive
  typedef logic [$clog2(FL_DEPTH+1)-1:0] fl_cnt_t;

  // Whole list contents, entry 0 in the low bits
  typedef preg_t [FL_DEPTH-1:0]          fl_mem_t;

endpackage : free_list_pkg

// File: design/rename_reg_pkg.sv
// ====================
// Register space of the rename subsystem
// Physical file is twice the architectural file
// Architectural register 0 is renamed like any other
// ====================

package rename_reg_pkg;

  // ====================
  // Sizes
  // ====================

  // Architectural registers seen by the ISA
  parameter int unsigned ARCH_REG_NUM = 32;

  // Physical registers in the register file
  parameter int unsigned PHY_REG_NUM  = 64;

  // ====================
  // Index types
  // ====================

  // Architectural register index
  typedef logic [$clog2(ARCH_REG_NUM)-1:0] areg_t;

  // Physical register index
  typedef logic [$clog2(PHY_REG_NUM)-1:0]  preg_t;

endpackage : rename_reg_pkg
